//--- hw/rv_decode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Data path and PC width
`define XLEN 32

// Register file address
`define REG_AW 5

`define INSTR_W 32

`endif

//--- hw/rv_isa_pkg.sv
`include "rv_decode_defines.svh"

package rv_isa_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        OP       = 7'b0110011,
        OP_IMM   = 7'b0010011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        BRANCH   = 7'b1100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        MISC_MEM = 7'b0001111,
        SYSTEM   = 7'b1110011
    } opcode_e;

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } instr_reg_t;

    // imm12 sits on top of funct7 and rs2
    typedef struct packed {
        logic [11:0]        imm12;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } instr_imm_t;

    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

//--- hw/decode_pkg.sv
package decode_pkg;

    // Immediate format picked by the second decode stage
    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } imm_fmt_e;

endpackage

//--- hw/decode_1st.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

module decode_1st import rv_isa_pkg::*; (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                stall,

    input  logic                instr_valid,
    input  logic [`XLEN-1:0]    instr_pc,
    input  logic [`INSTR_W-1:0] instr_word,

    output logic                d1_valid,
    output logic [`XLEN-1:0]    d1_pc,
    output logic [6:0]          d1_opcode,
    output logic [`REG_AW-1:0]  d1_rd,
    output logic [`REG_AW-1:0]  d1_rs1,
    output logic [`REG_AW-1:0]  d1_rs2,
    output logic [2:0]          d1_funct3,
    output logic [6:0]          d1_funct7,
    output logic [`XLEN-1:0]    d1_imm_i,
    output logic [`XLEN-1:0]    d1_imm_s,
    output logic [`XLEN-1:0]    d1_imm_b,
    output logic [`XLEN-1:0]    d1_imm_u,
    output logic [`XLEN-1:0]    d1_imm_j
);

    logic                valid_q;
    logic [`XLEN-1:0]    pc_q;
    instr_u              instr_q;
    logic [`INSTR_W-1:0] iw;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            valid_q <= 1'b0;
            pc_q    <= '0;
            instr_q <= '0;
        end else if (!stall) begin
            valid_q <= instr_valid;
            pc_q    <= instr_pc;
            instr_q <= instr_word;
        end
    end

    assign iw = instr_q;

    assign d1_valid  = valid_q;
    assign d1_pc     = pc_q;
    assign d1_opcode = instr_q.r.opcode;
    assign d1_rd     = instr_q.r.rd;
    assign d1_rs1    = instr_q.r.rs1;
    assign d1_rs2    = instr_q.r.rs2;
    assign d1_funct3 = instr_q.r.funct3;
    assign d1_funct7 = instr_q.r.funct7;

    // I form read through the immediate view
    assign d1_imm_i = {{(`XLEN-12){instr_q.i.imm12[11]}}, instr_q.i.imm12};
    assign d1_imm_s = {{(`XLEN-12){iw[31]}}, iw[31:25], iw[11:7]};

    // Branch and jump offsets are halfword aligned
    assign d1_imm_b = {{(`XLEN-13){iw[31]}}, iw[31], iw[7], iw[30:25], iw[11:8], 1'b0};
    assign d1_imm_j = {{(`XLEN-21){iw[31]}}, iw[31], iw[19:12], iw[20], iw[30:21], 1'b0};
    assign d1_imm_u = {iw[31:12], 12'b0};

endmodule

//--- hw/decode_2nd.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

module decode_2nd import rv_isa_pkg::*, decode_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               stall,

    input  logic               d1_valid,
    input  logic [`XLEN-1:0]   d1_pc,
    input  logic [6:0]         d1_opcode,
    input  logic [`REG_AW-1:0] d1_rd,
    input  logic [`REG_AW-1:0] d1_rs1,
    input  logic [`REG_AW-1:0] d1_rs2,
    input  logic [2:0]         d1_funct3,
    input  logic [6:0]         d1_funct7,
    input  logic [`XLEN-1:0]   d1_imm_i,
    input  logic [`XLEN-1:0]   d1_imm_s,
    input  logic [`XLEN-1:0]   d1_imm_b,
    input  logic [`XLEN-1:0]   d1_imm_u,
    input  logic [`XLEN-1:0]   d1_imm_j,

    output logic               d2_valid,
    output logic [`XLEN-1:0]   d2_pc,
    output logic [6:0]         d2_opcode,
    output logic [`REG_AW-1:0] d2_rd,
    output logic [`REG_AW-1:0] d2_rs1,
    output logic [`REG_AW-1:0] d2_rs2,
    output logic [2:0]         d2_funct3,
    output logic [6:0]         d2_funct7,
    output logic [`XLEN-1:0]   d2_imm,
    output imm_fmt_e           d2_fmt
);

    logic               valid_q;
    logic [`XLEN-1:0]   pc_q;
    logic [6:0]         opcode_q;
    logic [`REG_AW-1:0] rd_q;
    logic [`REG_AW-1:0] rs1_q;
    logic [`REG_AW-1:0] rs2_q;
    logic [2:0]         funct3_q;
    logic [6:0]         funct7_q;
    logic [`XLEN-1:0]   imm_i_q;
    logic [`XLEN-1:0]   imm_s_q;
    logic [`XLEN-1:0]   imm_b_q;
    logic [`XLEN-1:0]   imm_u_q;
    logic [`XLEN-1:0]   imm_j_q;
    imm_fmt_e           fmt;

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            valid_q  <= 1'b0;
            pc_q     <= '0;
            opcode_q <= '0;
            rd_q     <= '0;
            rs1_q    <= '0;
            rs2_q    <= '0;
            funct3_q <= '0;
            funct7_q <= '0;
            imm_i_q  <= '0;
            imm_s_q  <= '0;
            imm_b_q  <= '0;
            imm_u_q  <= '0;
            imm_j_q  <= '0;
        end else if (!stall) begin
            valid_q  <= d1_valid;
            pc_q     <= d1_pc;
            opcode_q <= d1_opcode;
            rd_q     <= d1_rd;
            rs1_q    <= d1_rs1;
            rs2_q    <= d1_rs2;
            funct3_q <= d1_funct3;
            funct7_q <= d1_funct7;
            imm_i_q  <= d1_imm_i;
            imm_s_q  <= d1_imm_s;
            imm_b_q  <= d1_imm_b;
            imm_u_q  <= d1_imm_u;
            imm_j_q  <= d1_imm_j;
        end
    end

    // One format per opcode, anything unknown falls to NONE
    always_comb begin
        case (opcode_q)
            OP:                                    fmt = FMT_R;
            JALR, LOAD, OP_IMM, MISC_MEM, SYSTEM:  fmt = FMT_I;
            STORE:                                 fmt = FMT_S;
            BRANCH:                                fmt = FMT_B;
            LUI, AUIPC:                            fmt = FMT_U;
            JAL:                                   fmt = FMT_J;
            default:                               fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I:   d2_imm = imm_i_q;
            FMT_S:   d2_imm = imm_s_q;
            FMT_B:   d2_imm = imm_b_q;
            FMT_U:   d2_imm = imm_u_q;
            FMT_J:   d2_imm = imm_j_q;
            default: d2_imm = '0;
        endcase
    end

    // Unsupported opcodes are dropped here
    assign d2_valid  = valid_q && (fmt != FMT_NONE);
    assign d2_fmt    = fmt;
    assign d2_pc     = pc_q;
    assign d2_opcode = opcode_q;
    assign d2_rd     = rd_q;
    assign d2_rs1    = rs1_q;
    assign d2_rs2    = rs2_q;
    assign d2_funct3 = funct3_q;
    assign d2_funct7 = funct7_q;

endmodule

//--- hw/reg_use_decode.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

module reg_use_decode import decode_pkg::*; (
    input  logic               CLK,
    input  logic               rst_n,
    input  logic               flush,
    input  logic               stall,

    input  logic               d2_valid,
    input  logic [`XLEN-1:0]   d2_pc,
    input  logic [6:0]         d2_opcode,
    input  logic [`REG_AW-1:0] d2_rd,
    input  logic [`REG_AW-1:0] d2_rs1,
    input  logic [`REG_AW-1:0] d2_rs2,
    input  logic [2:0]         d2_funct3,
    input  logic [6:0]         d2_funct7,
    input  logic [`XLEN-1:0]   d2_imm,
    input  imm_fmt_e           d2_fmt,

    output logic               op_valid,
    output logic [`XLEN-1:0]   op_pc,
    output logic [6:0]         op_opcode,
    output logic [`REG_AW-1:0] op_rd,
    output logic [`REG_AW-1:0] op_rs1,
    output logic [`REG_AW-1:0] op_rs2,
    output logic [2:0]         op_funct3,
    output logic [6:0]         op_funct7,
    output logic [`XLEN-1:0]   op_imm,
    output imm_fmt_e           op_fmt,
    output logic               op_rs1_use,
    output logic               op_rs2_use,
    output logic               op_rd_write
);

    logic rs1_use;
    logic rs2_use;
    logic rd_write;

    assign rs1_use  = d2_valid && (d2_fmt inside {FMT_R, FMT_I, FMT_S, FMT_B});
    assign rs2_use  = d2_valid && (d2_fmt inside {FMT_R, FMT_S, FMT_B});
    // Writes to x0 are discarded, so no write is reported
    assign rd_write = d2_valid && (d2_fmt inside {FMT_R, FMT_I, FMT_U, FMT_J})
                      && (d2_rd != '0);

    always_ff @(posedge CLK) begin
        if (!rst_n || flush) begin
            op_valid    <= 1'b0;
            op_pc       <= '0;
            op_opcode   <= '0;
            op_rd       <= '0;
            op_rs1      <= '0;
            op_rs2      <= '0;
            op_funct3   <= '0;
            op_funct7   <= '0;
            op_imm      <= '0;
            op_fmt      <= FMT_R;
            op_rs1_use  <= 1'b0;
            op_rs2_use  <= 1'b0;
            op_rd_write <= 1'b0;
        end else if (!stall) begin
            op_valid    <= d2_valid;
            op_pc       <= d2_pc;
            op_opcode   <= d2_opcode;
            op_rd       <= d2_rd;
            op_rs1      <= d2_rs1;
            op_rs2      <= d2_rs2;
            op_funct3   <= d2_funct3;
            op_funct7   <= d2_funct7;
            op_imm      <= d2_imm;
            op_fmt      <= d2_fmt;
            op_rs1_use  <= rs1_use;
            op_rs2_use  <= rs2_use;
            op_rd_write <= rd_write;
        end
    end

endmodule

//--- hw/rv_decode_top.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

module rv_decode_top import decode_pkg::*; (
    input  logic                CLK,
    input  logic                rst_n,
    input  logic                flush,
    input  logic                stall,

    input  logic                instr_valid,
    input  logic [`XLEN-1:0]    instr_pc,
    input  logic [`INSTR_W-1:0] instr_word,

    output logic                op_valid,
    output logic [`XLEN-1:0]    op_pc,
    output logic [6:0]          op_opcode,
    output logic [`REG_AW-1:0]  op_rd,
    output logic [`REG_AW-1:0]  op_rs1,
    output logic [`REG_AW-1:0]  op_rs2,
    output logic [2:0]          op_funct3,
    output logic [6:0]          op_funct7,
    output logic [`XLEN-1:0]    op_imm,
    output imm_fmt_e            op_fmt,
    output logic                op_rs1_use,
    output logic                op_rs2_use,
    output logic                op_rd_write
);

    logic               d1_valid;
    logic [`XLEN-1:0]   d1_pc;
    logic [6:0]         d1_opcode;
    logic [`REG_AW-1:0] d1_rd;
    logic [`REG_AW-1:0] d1_rs1;
    logic [`REG_AW-1:0] d1_rs2;
    logic [2:0]         d1_funct3;
    logic [6:0]         d1_funct7;
    logic [`XLEN-1:0]   d1_imm_i;
    logic [`XLEN-1:0]   d1_imm_s;
    logic [`XLEN-1:0]   d1_imm_b;
    logic [`XLEN-1:0]   d1_imm_u;
    logic [`XLEN-1:0]   d1_imm_j;

    logic               d2_valid;
    logic [`XLEN-1:0]   d2_pc;
    logic [6:0]         d2_opcode;
    logic [`REG_AW-1:0] d2_rd;
    logic [`REG_AW-1:0] d2_rs1;
    logic [`REG_AW-1:0] d2_rs2;
    logic [2:0]         d2_funct3;
    logic [6:0]         d2_funct7;
    logic [`XLEN-1:0]   d2_imm;
    imm_fmt_e           d2_fmt;

    // Field split and immediate build
    decode_1st u_decode_1st (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .flush       (flush),
        .stall       (stall),
        .instr_valid (instr_valid),
        .instr_pc    (instr_pc),
        .instr_word  (instr_word),
        .d1_valid    (d1_valid),
        .d1_pc       (d1_pc),
        .d1_opcode   (d1_opcode),
        .d1_rd       (d1_rd),
        .d1_rs1      (d1_rs1),
        .d1_rs2      (d1_rs2),
        .d1_funct3   (d1_funct3),
        .d1_funct7   (d1_funct7),
        .d1_imm_i    (d1_imm_i),
        .d1_imm_s    (d1_imm_s),
        .d1_imm_b    (d1_imm_b),
        .d1_imm_u    (d1_imm_u),
        .d1_imm_j    (d1_imm_j)
    );

    // Format select
    decode_2nd u_decode_2nd (
        .CLK       (CLK),
        .rst_n     (rst_n),
        .flush     (flush),
        .stall     (stall),
        .d1_valid  (d1_valid),
        .d1_pc     (d1_pc),
        .d1_opcode (d1_opcode),
        .d1_rd     (d1_rd),
        .d1_rs1    (d1_rs1),
        .d1_rs2    (d1_rs2),
        .d1_funct3 (d1_funct3),
        .d1_funct7 (d1_funct7),
        .d1_imm_i  (d1_imm_i),
        .d1_imm_s  (d1_imm_s),
        .d1_imm_b  (d1_imm_b),
        .d1_imm_u  (d1_imm_u),
        .d1_imm_j  (d1_imm_j),
        .d2_valid  (d2_valid),
        .d2_pc     (d2_pc),
        .d2_opcode (d2_opcode),
        .d2_rd     (d2_rd),
        .d2_rs1    (d2_rs1),
        .d2_rs2    (d2_rs2),
        .d2_funct3 (d2_funct3),
        .d2_funct7 (d2_funct7),
        .d2_imm    (d2_imm),
        .d2_fmt    (d2_fmt)
    );

    // Operand use flags and issue register
    reg_use_decode u_reg_use_decode (
        .CLK         (CLK),
        .rst_n       (rst_n),
        .flush       (flush),
        .stall       (stall),
        .d2_valid    (d2_valid),
        .d2_pc       (d2_pc),
        .d2_opcode   (d2_opcode),
        .d2_rd       (d2_rd),
        .d2_rs1      (d2_rs1),
        .d2_rs2      (d2_rs2),
        .d2_funct3   (d2_funct3),
        .d2_funct7   (d2_funct7),
        .d2_imm      (d2_imm),
        .d2_fmt      (d2_fmt),
        .op_valid    (op_valid),
        .op_pc       (op_pc),
        .op_opcode   (op_opcode),
        .op_rd       (op_rd),
        .op_rs1      (op_rs1),
        .op_rs2      (op_rs2),
        .op_funct3   (op_funct3),
        .op_funct7   (op_funct7),
        .op_imm      (op_imm),
        .op_fmt      (op_fmt),
        .op_rs1_use  (op_rs1_use),
        .op_rs2_use  (op_rs2_use),
        .op_rd_write (op_rd_write)
    );

endmodule

//--- verif/rv_decode_chk.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

module rv_decode_chk import rv_isa_pkg::*, decode_pkg::*; (
    input logic                CLK,
    input logic                rst_n,
    input logic                flush,
    input logic                stall,
    input logic                instr_valid,
    input logic [`INSTR_W-1:0] instr_word,
    input logic                op_valid,
    input logic [`XLEN-1:0]    op_pc,
    input logic [6:0]          op_opcode,
    input logic [`REG_AW-1:0]  op_rd,
    input logic [`REG_AW-1:0]  op_rs1,
    input logic [`REG_AW-1:0]  op_rs2,
    input logic [2:0]          op_funct3,
    input logic [6:0]          op_funct7,
    input logic [`XLEN-1:0]    op_imm,
    input imm_fmt_e            op_fmt,
    input logic                op_rs1_use,
    input logic                op_rs2_use,
    input logic                op_rd_write
);

    logic accept_ok;
    int   fail_count = 0;

    // Supported word taken by the first stage
    assign accept_ok = instr_valid && !stall && !flush
                       && (instr_word[6:0] inside {OP, OP_IMM, LOAD, STORE, BRANCH, JAL,
                                                   JALR, LUI, AUIPC, MISC_MEM, SYSTEM});

    a_latency: assert property (@(posedge CLK) disable iff (!rst_n)
        accept_ok ##1 (!stall && !flush) ##1 (!stall && !flush) |=> op_valid)
        else begin
            fail_count++;
            $error("op_valid missing three cycles after an accepted instruction");
        end

    a_stall_hold: assert property (@(posedge CLK)
        (rst_n && stall && !flush) |=> $stable({op_valid, op_pc, op_opcode, op_rd, op_rs1,
            op_rs2, op_funct3, op_funct7, op_imm, op_fmt, op_rs1_use, op_rs2_use,
            op_rd_write}))
        else begin
            fail_count++;
            $error("outputs changed while stall was high");
        end

    a_flush: assert property (@(posedge CLK) flush |=> !op_valid)
        else begin
            fail_count++;
            $error("op_valid high one cycle after flush");
        end

    a_reset: assert property (@(posedge CLK)
        !rst_n |=> (!op_valid && !op_rs1_use && !op_rs2_use && !op_rd_write))
        else begin
            fail_count++;
            $error("op_valid or a use flag high during or right after reset");
        end

    a_fmt: assert property (@(posedge CLK) disable iff (!rst_n)
        op_valid |-> (op_fmt != FMT_NONE))
        else begin
            fail_count++;
            $error("op_valid high with no immediate format");
        end

endmodule

//--- verif/rv_decode_tb.sv
`timescale 1ns/10ps
`include "rv_decode_defines.svh"

bind rv_decode_top rv_decode_chk chk0 (.*);

module rv_decode_tb import rv_isa_pkg::*, decode_pkg::*;;

    localparam int CLK_PERIOD = 40;
    localparam int N_DIRECTED = 26;
    localparam int N_RANDOM   = 300;
    localparam int N_INSTR    = N_DIRECTED + N_RANDOM;

    typedef struct packed {
        logic [`XLEN-1:0]   pc;
        logic [6:0]         opcode;
        logic [`REG_AW-1:0] rd;
        logic [`REG_AW-1:0] rs1;
        logic [`REG_AW-1:0] rs2;
        logic [2:0]         funct3;
        logic [6:0]         funct7;
        logic [`XLEN-1:0]   imm;
        imm_fmt_e           fmt;
        logic               rs1_use;
        logic               rs2_use;
        logic               rd_write;
    } op_rec_t;

    logic                CLK;
    logic                rst_n;
    logic                flush;
    logic                stall;
    logic                instr_valid;
    logic [`XLEN-1:0]    instr_pc;
    logic [`INSTR_W-1:0] instr_word;
    logic                op_valid;
    logic [`XLEN-1:0]    op_pc;
    logic [6:0]          op_opcode;
    logic [`REG_AW-1:0]  op_rd;
    logic [`REG_AW-1:0]  op_rs1;
    logic [`REG_AW-1:0]  op_rs2;
    logic [2:0]          op_funct3;
    logic [6:0]          op_funct7;
    logic [`XLEN-1:0]    op_imm;
    imm_fmt_e            op_fmt;
    logic                op_rs1_use;
    logic                op_rs2_use;
    logic                op_rd_write;

    op_rec_t             exp_q[$];
    op_rec_t             exp_new;
    op_rec_t             exp_op;
    instr_u              rand_word;
    int                  errors;
    int                  checks;
    int                  k;
    int                  n;
    integer              seed;
    logic [`XLEN-1:0]    pc_next;
    logic [3:0]          idx;
    logic                v_rand;
    logic                s_rand;
    logic                f_rand;
    bit                  fresh;

    // Last two entries are not RV32I base opcodes
    logic [6:0] op_table [0:12] = '{OP, OP_IMM, LOAD, STORE, BRANCH, JAL, JALR, LUI,
                                    AUIPC, MISC_MEM, SYSTEM, 7'h7f, 7'h00};

    rv_decode_top dut0 (.*);

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    function automatic logic [`INSTR_W-1:0] encode_r(input logic [6:0] opcode,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
            input logic [2:0] funct3, input logic [6:0] funct7);
        instr_u iw;
        iw.r.opcode = opcode;
        iw.r.rd     = rd;
        iw.r.rs1    = rs1;
        iw.r.rs2    = rs2;
        iw.r.funct3 = funct3;
        iw.r.funct7 = funct7;
        return iw;
    endfunction

    function automatic logic [`INSTR_W-1:0] encode_i(input logic [6:0] opcode,
            input logic [4:0] rd, input logic [4:0] rs1, input logic [2:0] funct3,
            input logic [11:0] imm12);
        instr_u iw;
        iw.i.opcode = opcode;
        iw.i.rd     = rd;
        iw.i.rs1    = rs1;
        iw.i.funct3 = funct3;
        iw.i.imm12  = imm12;
        return iw;
    endfunction

    // Expected issue record straight from the RV32I encoding rules
    function automatic op_rec_t expect_op(input logic [31:0] pc, input logic [31:0] w);
        op_rec_t  r;
        imm_fmt_e f;
        case (w[6:0])
            OP:                                   f = FMT_R;
            LOAD, OP_IMM, JALR, MISC_MEM, SYSTEM: f = FMT_I;
            STORE:                                f = FMT_S;
            BRANCH:                               f = FMT_B;
            LUI, AUIPC:                           f = FMT_U;
            JAL:                                  f = FMT_J;
            default:                              f = FMT_NONE;
        endcase
        case (f)
            FMT_I:   r.imm = $signed(w) >>> 20;
            FMT_S:   r.imm = $signed({w[31:25], w[11:7], 20'b0}) >>> 20;
            FMT_B:   r.imm = $signed({w[31], w[7], w[30:25], w[11:8], 20'b0}) >>> 19;
            FMT_U:   r.imm = {w[31:12], 12'b0};
            FMT_J:   r.imm = $signed({w[31], w[19:12], w[20], w[30:21], 12'b0}) >>> 11;
            default: r.imm = '0;
        endcase
        r.pc       = pc;
        r.opcode   = w[6:0];
        r.rd       = w[11:7];
        r.funct3   = w[14:12];
        r.rs1      = w[19:15];
        r.rs2      = w[24:20];
        r.funct7   = w[31:25];
        r.fmt      = f;
        r.rs1_use  = f inside {FMT_R, FMT_I, FMT_S, FMT_B};
        r.rs2_use  = f inside {FMT_R, FMT_S, FMT_B};
        r.rd_write = (f inside {FMT_R, FMT_I, FMT_U, FMT_J}) && (r.rd != '0);
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] got,
            input logic [31:0] want);
        checks++;
        assert (got == want) else begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
        end
    endtask

    task automatic drive(input logic v, input logic [31:0] w, input logic s,
            input logic f);
        @(posedge CLK);
        instr_valid <= v;
        instr_word  <= w;
        instr_pc    <= pc_next;
        stall       <= s;
        flush       <= f;
        if (v)
            pc_next = pc_next + 32'd4;
    endtask

    // Reference model, sees inputs as the DUT samples them
    always @(posedge CLK) begin
        if (!rst_n || flush) begin
            exp_q.delete();
            fresh = 1'b0;
        end else if (!stall) begin
            fresh = 1'b1;
            if (instr_valid) begin
                exp_new = expect_op(instr_pc, instr_word);
                if (exp_new.fmt != FMT_NONE)
                    exp_q.push_back(exp_new);
            end
        end else begin
            fresh = 1'b0;
        end
    end

    always @(negedge CLK) begin
        if (fresh && op_valid) begin
            assert (exp_q.size() > 0) else begin
                errors++;
                $display("Error at %0t ns: op_valid high with no instruction expected",
                         $time);
            end
            if (exp_q.size() > 0) begin
                exp_op = exp_q.pop_front();
                check_field("op_pc", op_pc, exp_op.pc);
                check_field("op_opcode", 32'(op_opcode), 32'(exp_op.opcode));
                check_field("op_rd", 32'(op_rd), 32'(exp_op.rd));
                check_field("op_rs1", 32'(op_rs1), 32'(exp_op.rs1));
                check_field("op_rs2", 32'(op_rs2), 32'(exp_op.rs2));
                check_field("op_funct3", 32'(op_funct3), 32'(exp_op.funct3));
                check_field("op_funct7", 32'(op_funct7), 32'(exp_op.funct7));
                check_field("op_imm", op_imm, exp_op.imm);
                check_field("op_fmt", 32'(op_fmt), 32'(exp_op.fmt));
                check_field("op_rs1_use", 32'(op_rs1_use), 32'(exp_op.rs1_use));
                check_field("op_rs2_use", 32'(op_rs2_use), 32'(exp_op.rs2_use));
                check_field("op_rd_write", 32'(op_rd_write), 32'(exp_op.rd_write));
            end
        end
        if (!op_valid)
            check_field("idle use flags", 32'({op_rs1_use, op_rs2_use, op_rd_write}), 0);
    end

    initial begin
        #((N_INSTR * 4 + 50) * CLK_PERIOD);
        $display("Timeout: the test did not finish in the expected time");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        CLK         = 1'b0;
        rst_n       = 1'b0;
        flush       = 1'b0;
        stall       = 1'b0;
        instr_valid = 1'b0;
        instr_pc    = '0;
        instr_word  = '0;
        seed        = 53145;
        pc_next     = 32'h0000_1000;
        errors      = 0;
        checks      = 0;
        fresh       = 1'b0;
        repeat (5) @(posedge CLK);
        rst_n <= 1'b1;

        // Every opcode, negative immediates and rd walking from x0
        for (k = 0; k < 13; k++)
            drive(1'b1, encode_r(op_table[4'(k)], 5'(k), 5'(k + 3), 5'(31 - k), 3'(k),
                                 7'h40 | 7'(k)), 1'b0, 1'b0);
        // Every opcode again, positive immediates and rd = x0
        for (k = 0; k < 13; k++)
            drive(1'b1, encode_i(op_table[4'(k)], 5'd0, 5'(k + 1), 3'(7 - k),
                                 12'h7f0 + 12'(k)), 1'b0, 1'b0);

        // Random words with rare stall and flush
        for (n = 0; n < N_RANDOM; n++) begin
            rand_word        = $random(seed);
            idx              = 4'($unsigned($random(seed)) % 13);
            rand_word.r.opcode = op_table[idx];
            v_rand           = ($random(seed) & 3) != 0;
            s_rand           = ($random(seed) & 15) == 0;
            f_rand           = ($random(seed) & 31) == 0;
            drive(v_rand, rand_word, s_rand, f_rand);
        end

        repeat (8) drive(1'b0, '0, 1'b0, 1'b0);
        @(negedge CLK);
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("%0d instructions never came out of the pipeline", exp_q.size());
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut0.chk0.fail_count);
        if (errors == 0 && dut0.chk0.fail_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- rv_decode_top.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/decode_pkg.sv
hw/decode_1st.sv
hw/decode_2nd.sv
hw/reg_use_decode.sv
hw/rv_decode_top.sv
verif/rv_decode_chk.sv
verif/rv_decode_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decode front end testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f rv_decode_top.f \
    --top-module rv_decode_tb -Mdir obj_dir -o rv_decode_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/rv_decode_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
